/* all.f */
verilog/video_pkg.sv
verilog/raster_timer.sv
verilog/fetch_fsm.sv
verilog/video_ram.sv
verilog/pattern_latch.sv
verilog/pixel_color.sv
verilog/video_top.sv
sim/video_tb.sv

/* sim/video_tb.sv */
module video_tb import video_pkg::*; ();

  localparam int         text_char_w       = 6;
  localparam int         gfx_char_w        = 8;
  localparam int         gfx_cols          = SCREEN_W / gfx_char_w;
  localparam int         cpu_test_writes   = 64;
  localparam vram_addr_t text_name_base    = 14'h3000;
  localparam vram_addr_t text_pattern_base = 14'h2800;
  localparam vram_data_t text_char         = 8'h41;
  localparam vram_addr_t gfx_name_base     = 14'h1800;
  localparam vram_addr_t gfx_pattern_base  = 14'h0000;
  localparam vram_addr_t gfx_color_base    = 14'h2000;

  logic        clk;
  logic        reset;
  video_regs_t regs;
  vram_addr_t  cpu_addr;
  vram_data_t  cpu_wdata;
  logic        cpu_we;
  logic        cpu_re;
  logic [7:0]  vga_r;
  logic [7:0]  vga_g;
  logic [7:0]  vga_b;
  logic        vga_hs;
  logic        vga_vs;
  logic        vga_de;
  vram_data_t  cpu_rdata;
  logic        n_int;
  hcount_t     h_counter;
  vcount_t     v_counter;
  rgb_t        vga_rgb;

  // Model of the RAM contents, written alongside the CPU port
  vram_data_t  model [VRAM_DEPTH];
  vram_addr_t  cpu_addrs [$];
  integer      seed = 32'h131;
  string       test_name = "reset";
  logic        check_pixels = 1'b0;
  logic        int_check = 1'b0;
  rgb_t        exp_rgb;
  logic        read_pending = 1'b0;
  vram_data_t  read_expect;
  vram_addr_t  read_addr;
  logic        prev_n_int = 1'b1;
  hcount_t     prev_h;
  vcount_t     prev_v;
  int          int_low_len;
  int          int_pulses;
  logic        prev_hs;
  logic        prev_vs;
  logic        hs_seen;
  logic        vs_seen;
  int          hs_low;
  int          hs_period;
  int          vs_low;
  int          vs_period;
  hcount_t     ref_h;
  vcount_t     ref_v;

  video_top video_top_i (
    .clk       (clk),
    .reset     (reset),
    .regs      (regs),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_we    (cpu_we),
    .cpu_re    (cpu_re),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .vga_hs    (vga_hs),
    .vga_vs    (vga_vs),
    .vga_de    (vga_de),
    .cpu_rdata (cpu_rdata),
    .n_int     (n_int),
    .h_counter (h_counter),
    .v_counter (v_counter)
  );

  assign vga_rgb = {vga_r, vga_g, vga_b};

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run;
    $display("Verification failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Error in %s, %s: expected %0h, actual %0h", test_name, what, expected, actual);
    abort_run();
  endtask

  task automatic report_problem(input string text);
    $display("%s", text);
    abort_run();
  endtask

  task automatic write_byte(input vram_addr_t addr, input vram_data_t data);
    @(negedge clk);
    cpu_addr  = addr;
    cpu_wdata = data;
    cpu_we    = 1'b1;
    cpu_re    = 1'b0;
    model[addr] = data;
  endtask

  task automatic read_byte(input vram_addr_t addr);
    @(negedge clk);
    cpu_addr = addr;
    cpu_we   = 1'b0;
    cpu_re   = 1'b1;
  endtask

  task automatic cpu_idle;
    @(negedge clk);
    cpu_we = 1'b0;
    cpu_re = 1'b0;
  endtask

  // Returns on the falling edge inside raster position 0,0
  task automatic wait_frame_start;
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!(h_counter == 0 && v_counter == 0)) begin
      if (cycles > H_TOTAL * V_TOTAL) begin
        report_problem("Timeout while waiting for the start of a frame");
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  // Settle one partial frame, then check one whole frame
  task automatic check_frame(input string name, input int expected_pulses);
    test_name = name;
    wait_frame_start();
    check_pixels = 1'b1;
    int_check    = 1'b1;
    wait_frame_start();
    assert (int_pulses == expected_pulses)
      else report_mismatch("interrupt pulses", expected_pulses, int_pulses);
    check_pixels = 1'b0;
    int_check    = 1'b0;
  endtask

  // Colour for one raster position, from the model RAM and the mode rules
  function automatic rgb_t expected_rgb(input int h, input int v);
    int           y;
    int           col;
    int           pix;
    int           text_left;
    vram_data_t   name;
    vram_data_t   pattern;
    vram_data_t   color;
    color_index_t index;
    index     = regs.back_color;
    text_left = H_BORDER + 2 * TEXT_LEFT;
    y         = (v - V_BORDER) / 2;
    if (h >= H_ACTIVE || v >= V_ACTIVE) begin
      return '0;
    end
    if (regs.video_on && v >= V_BORDER && v < V_BORDER + 2 * SCREEN_H) begin
      if (regs.mode == TEXT_MODE && h >= text_left &&
          h < text_left + 2 * text_char_w * TEXT_COLS) begin
        col     = (h - text_left) / (2 * text_char_w);
        pix     = ((h - text_left) % (2 * text_char_w)) / 2;
        name    = model[vram_addr_t'(regs.name_table_addr + (y / 8) * TEXT_COLS + col)];
        pattern = model[vram_addr_t'(regs.pattern_table_addr + name * 8 + y % 8)];
        index   = pattern[7 - pix] ? regs.text_color : regs.back_color;
      end else if (regs.mode == GRAPHICS_MODE && h >= H_BORDER &&
                   h < H_BORDER + 2 * SCREEN_W) begin
        col     = (h - H_BORDER) / (2 * gfx_char_w);
        pix     = ((h - H_BORDER) % (2 * gfx_char_w)) / 2;
        name    = model[vram_addr_t'(regs.name_table_addr + (y / 8) * gfx_cols + col)];
        pattern = model[vram_addr_t'(regs.pattern_table_addr + name * 8 + y % 8)];
        color   = model[vram_addr_t'(regs.color_table_addr + name / 8)];
        index   = pattern[7 - pix] ? color[7:4] : color[3:0];
      end
    end
    // Transparent falls back to the background
    if (index == '0) begin
      index = regs.back_color;
    end
    return PALETTE[index];
  endfunction

  // CPU read data, one cycle after the strobe
  always @(posedge clk) begin
    if (read_pending) begin
      assert (cpu_rdata == read_expect)
        else report_mismatch($sformatf("cpu read at %0h", read_addr), read_expect, cpu_rdata);
    end
    read_pending <= cpu_re && !reset;
    read_expect  <= model[cpu_addr];
    read_addr    <= cpu_addr;
  end

  always @(posedge clk) begin
    if (check_pixels) begin
      exp_rgb = expected_rgb(h_counter, v_counter);
      assert (vga_rgb == exp_rgb)
        else report_mismatch($sformatf("pixel at h %0d v %0d", h_counter, v_counter),
                             exp_rgb, vga_rgb);
    end
  end

  // Raster counters, sync periods and widths, display enable and blanking
  always @(posedge clk) begin
    if (reset) begin
      prev_hs   <= 1'b1;
      prev_vs   <= 1'b1;
      hs_seen   <= 1'b0;
      vs_seen   <= 1'b0;
      hs_low    <= 0;
      vs_low    <= 0;
      hs_period <= 0;
      vs_period <= 0;
      ref_h     <= '0;
      ref_v     <= '0;
    end else begin
      assert (h_counter == ref_h) else report_mismatch("h_counter", ref_h, h_counter);
      assert (v_counter == ref_v) else report_mismatch("v_counter", ref_v, v_counter);
      if (ref_h == H_TOTAL - 1) begin
        ref_h <= '0;
        ref_v <= (ref_v == V_TOTAL - 1) ? '0 : ref_v + 1'b1;
      end else begin
        ref_h <= ref_h + 1'b1;
      end
      assert (vga_de == (h_counter < H_ACTIVE && v_counter < V_ACTIVE))
        else report_mismatch($sformatf("vga_de at h %0d v %0d", h_counter, v_counter),
                             h_counter < H_ACTIVE && v_counter < V_ACTIVE, vga_de);
      if (!vga_de) begin
        assert (vga_rgb == '0) else report_mismatch("blanking", 0, vga_rgb);
      end
      if (prev_hs && !vga_hs) begin
        if (hs_seen) begin
          assert (hs_period == H_TOTAL) else report_mismatch("hsync period", H_TOTAL, hs_period);
        end
        hs_seen   <= 1'b1;
        hs_period <= 1;
      end else begin
        hs_period <= hs_period + 1;
      end
      if (!vga_hs) begin
        hs_low <= hs_low + 1;
      end else if (!prev_hs) begin
        assert (hs_low == H_SYNC) else report_mismatch("hsync width", H_SYNC, hs_low);
        hs_low <= 0;
      end
      if (prev_vs && !vga_vs) begin
        if (vs_seen) begin
          assert (vs_period == H_TOTAL * V_TOTAL)
            else report_mismatch("vsync period", H_TOTAL * V_TOTAL, vs_period);
        end
        vs_seen   <= 1'b1;
        vs_period <= 1;
      end else begin
        vs_period <= vs_period + 1;
      end
      if (!vga_vs) begin
        vs_low <= vs_low + 1;
      end else if (!prev_vs) begin
        assert (vs_low == V_SYNC * H_TOTAL)
          else report_mismatch("vsync width", V_SYNC * H_TOTAL, vs_low);
        vs_low <= 0;
      end
      prev_hs <= vga_hs;
      prev_vs <= vga_vs;
    end
  end

  // Interrupt position, length and count per frame
  always @(posedge clk) begin
    if (!int_check) begin
      int_low_len <= 0;
      int_pulses  <= 0;
    end else if (!n_int) begin
      if (prev_n_int) begin
        assert (prev_h == H_ACTIVE + H_FRONT && prev_v == V_ACTIVE + V_FRONT)
          else report_problem("The interrupt went low at the wrong raster position");
        int_pulses <= int_pulses + 1;
      end
      int_low_len <= int_low_len + 1;
    end else if (!prev_n_int) begin
      assert (int_low_len == INT_PULSE_LEN)
        else report_mismatch("interrupt length", INT_PULSE_LEN, int_low_len);
      int_low_len <= 0;
    end
    prev_n_int <= n_int;
    prev_h     <= h_counter;
    prev_v     <= v_counter;
  end

  initial begin
    int         i;
    vram_addr_t addr;
    reset     = 1'b1;
    regs      = '0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    cpu_we    = 1'b0;
    cpu_re    = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    test_name = "cpu port";
    for (i = 0; i < cpu_test_writes; i++) begin
      addr = vram_addr_t'($random(seed));
      write_byte(addr, vram_data_t'($random(seed)));
      cpu_addrs.push_back(addr);
    end
    for (i = 0; i < cpu_addrs.size(); i++) begin
      read_byte(cpu_addrs[i]);
    end
    cpu_idle();
    @(negedge clk);

    // One character everywhere, lit on even rows only
    for (i = 0; i < TEXT_COLS * SCREEN_H / 8; i++) begin
      write_byte(text_name_base + vram_addr_t'(i), text_char);
    end
    for (i = 0; i < 8; i++) begin
      write_byte(text_pattern_base + vram_addr_t'(text_char * 8 + i),
                 (i % 2 == 0) ? 8'hfc : 8'h00);
    end
    cpu_idle();
    regs.mode               = TEXT_MODE;
    regs.video_on           = 1'b1;
    regs.vert_retrace_int   = 1'b1;
    regs.name_table_addr    = text_name_base;
    regs.pattern_table_addr = text_pattern_base;
    regs.color_table_addr   = '0;
    regs.text_color         = 4'hf;
    regs.back_color         = 4'h4;
    check_frame("text mode", 1);

    for (i = 0; i < gfx_cols * SCREEN_H / 8; i++) begin
      write_byte(gfx_name_base + vram_addr_t'(i), vram_data_t'($random(seed)));
    end
    for (i = 0; i < 256 * 8; i++) begin
      write_byte(gfx_pattern_base + vram_addr_t'(i), vram_data_t'($random(seed)));
    end
    for (i = 0; i < 32; i++) begin
      write_byte(gfx_color_base + vram_addr_t'(i), vram_data_t'($random(seed)));
    end
    cpu_idle();
    regs.mode               = GRAPHICS_MODE;
    regs.vert_retrace_int   = 1'b0;
    regs.name_table_addr    = gfx_name_base;
    regs.pattern_table_addr = gfx_pattern_base;
    regs.color_table_addr   = gfx_color_base;
    regs.back_color         = 4'h1;
    check_frame("graphics mode", 0);

    @(negedge clk);
    regs.video_on         = 1'b0;
    regs.vert_retrace_int = 1'b1;
    regs.back_color       = 4'hd;
    check_frame("video off", 1);

    $display("Verification passed");
    $finish;
  end

endmodule

/* verilog/fetch_fsm.sv */
module fetch_fsm import video_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  video_regs_t regs,
  input  raster_pos_t pos,
  input  vram_data_t  vid_data,
  output vram_addr_t  vid_addr,
  output logic        load_pattern,
  output logic        load_color
);

  fetch_state_t state;
  logic         graphics;
  logic [5:0]   next_col;
  logic [4:0]   row;
  logic [2:0]   line;
  logic [2:0]   start_pix;
  logic         in_rows;
  logic         col_valid;
  logic         start;
  vram_data_t   name_reg;
  vram_data_t   pat_name;
  vram_addr_t   name_addr;
  vram_addr_t   pattern_addr;
  vram_addr_t   color_addr;

  always_comb begin
    graphics = regs.mode == GRAPHICS_MODE;
    next_col = pos.char_col + 6'd1;
    row      = pos.y[7:3];
    line     = pos.y[2:0];

    // Start so that the pattern byte lands in the last half of the cell
    start_pix = graphics ? 3'd3 : 3'd2;
    in_rows   = pos.vcount >= V_BORDER && pos.vcount < V_BORDER + 2 * SCREEN_H;
    col_valid = graphics ? next_col < GFX_COLS : next_col < TEXT_COLS;
    start     = regs.video_on && in_rows && col_valid && pos.half_pixel &&
                pos.char_pix == start_pix;

    if (graphics) begin
      name_addr = regs.name_table_addr + vram_addr_t'({row, next_col[4:0]});
    end else begin
      name_addr = regs.name_table_addr + vram_addr_t'(row * TEXT_COLS + next_col);
    end

    // In text mode the name byte is still on the read port here
    pat_name     = graphics ? name_reg : vid_data;
    pattern_addr = regs.pattern_table_addr + vram_addr_t'({pat_name, line});
    color_addr   = regs.color_table_addr + vram_addr_t'(vid_data[7:3]);

    load_color   = state == PATTERN_ADDR && pos.half_pixel && graphics;
    load_pattern = state == STORE && pos.half_pixel;
  end

  // State steps only on the second cycle of each screen pixel
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= NAME_ADDR;
          end
        end
        NAME_ADDR: begin
          if (pos.half_pixel) begin
            state <= graphics ? COLOR_ADDR : PATTERN_ADDR;
          end
        end
        COLOR_ADDR: begin
          if (pos.half_pixel) begin
            state <= PATTERN_ADDR;
          end
        end
        PATTERN_ADDR: begin
          if (pos.half_pixel) begin
            state <= STORE;
          end
        end
        STORE: begin
          if (pos.half_pixel) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pos.half_pixel) begin
      case (state)
        NAME_ADDR: begin
          vid_addr <= name_addr;
        end
        COLOR_ADDR: begin
          // Name byte is needed again for the pattern read
          name_reg <= vid_data;
          vid_addr <= color_addr;
        end
        PATTERN_ADDR: begin
          vid_addr <= pattern_addr;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* verilog/pattern_latch.sv */
module pattern_latch import video_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  raster_pos_t pos,
  input  vram_data_t  vid_data,
  input  logic        load_pattern,
  input  logic        load_color,
  output logic        pattern_bit,
  output vram_data_t  cell_color
);

  vram_data_t color_next;
  vram_data_t pattern_cur;

  // Colour byte arrives first and waits for its pattern
  always_ff @(posedge clk) begin
    if (load_color) begin
      color_next <= vid_data;
    end
  end

  // Pattern load falls on the edge where the cell changes
  always_ff @(posedge clk) begin
    if (reset) begin
      pattern_cur <= '0;
      cell_color  <= '0;
    end else if (load_pattern) begin
      pattern_cur <= vid_data;
      cell_color  <= color_next;
    end
  end

  // Leftmost pixel is the MSB
  assign pattern_bit = pattern_cur[3'd7 - pos.char_pix];

endmodule

/* verilog/pixel_color.sv */
module pixel_color import video_pkg::*; (
  input  video_regs_t regs,
  input  raster_pos_t pos,
  input  logic        pattern_bit,
  input  vram_data_t  cell_color,
  output logic [7:0]  vga_r,
  output logic [7:0]  vga_g,
  output logic [7:0]  vga_b,
  output logic        vga_de
);

  color_index_t mode_index;
  color_index_t index;
  rgb_t         rgb;

  always_comb begin
    if (pos.border || !regs.video_on) begin
      mode_index = regs.back_color;
    end else if (regs.mode == TEXT_MODE) begin
      mode_index = pattern_bit ? regs.text_color : regs.back_color;
    end else begin
      // Foreground in the upper nibble
      mode_index = pattern_bit ? cell_color[7:4] : cell_color[3:0];
    end

    // Transparent shows the background
    index = (mode_index == '0) ? regs.back_color : mode_index;

    rgb = pos.de ? PALETTE[index] : '0;
  end

  assign vga_r  = rgb[23:16];
  assign vga_g  = rgb[15:8];
  assign vga_b  = rgb[7:0];
  assign vga_de = pos.de;

endmodule

/* verilog/raster_timer.sv */
module raster_timer import video_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  video_regs_t regs,
  output raster_pos_t pos,
  output logic        vga_hs,
  output logic        vga_vs,
  output logic        n_int
);

  hcount_t                hcount;
  vcount_t                vcount;
  logic [5:0]             char_col;
  logic [2:0]             char_pix;
  logic [3:0]             char_w;
  hcount_t                left_edge;
  hcount_t                right_edge;
  hcount_t                preload_h;
  hcount_t                h_off;
  vcount_t                v_off;
  logic                   h_border;
  logic                   v_border;
  logic                   int_active;
  logic [INT_CNT_W-1:0]   int_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      hcount <= '0;
      vcount <= '0;
    end else if (hcount == H_TOTAL - 1) begin
      hcount <= '0;
      vcount <= (vcount == V_TOTAL - 1) ? '0 : vcount + 10'd1;
    end else begin
      hcount <= hcount + 10'd1;
    end
  end

  // Drawn area and cell width depend on the mode
  always_comb begin
    if (regs.mode == TEXT_MODE) begin
      char_w     = 4'(CHAR_W_TEXT);
      left_edge  = hcount_t'(H_BORDER + 2 * TEXT_LEFT);
      right_edge = hcount_t'(H_BORDER + 2 * (TEXT_LEFT + CHAR_W_TEXT * TEXT_COLS));
    end else begin
      char_w     = 4'(CHAR_W_GFX);
      left_edge  = hcount_t'(H_BORDER);
      right_edge = hcount_t'(H_BORDER + 2 * SCREEN_W);
    end
    // One spare cell before column 0 gives the fetch its time
    preload_h = left_edge - hcount_t'(2 * char_w + 1);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      char_pix <= '0;
      char_col <= '0;
    end else if (hcount == preload_h) begin
      char_pix <= '0;
      char_col <= '1;
    end else if (hcount[0]) begin
      if (char_pix == 3'(char_w - 4'd1)) begin
        char_pix <= '0;
        char_col <= char_col + 6'd1;
      end else begin
        char_pix <= char_pix + 3'd1;
      end
    end
  end

  // Vertical retrace interrupt, low for a fixed number of cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      int_active <= 1'b0;
      int_cnt    <= '0;
    end else if (hcount == H_ACTIVE + H_FRONT && vcount == V_ACTIVE + V_FRONT &&
                 regs.vert_retrace_int) begin
      int_active <= 1'b1;
      int_cnt    <= INT_CNT_W'(INT_PULSE_LEN - 1);
    end else if (int_active) begin
      if (int_cnt == '0) begin
        int_active <= 1'b0;
      end else begin
        int_cnt <= int_cnt - 1'b1;
      end
    end
  end

  always_comb begin
    h_off    = hcount - hcount_t'(H_BORDER);
    v_off    = vcount - vcount_t'(V_BORDER);
    h_border = hcount < left_edge || hcount >= right_edge;
    v_border = vcount < V_BORDER || vcount >= V_BORDER + 2 * SCREEN_H;

    pos.hcount     = hcount;
    pos.vcount     = vcount;
    pos.x          = h_off[8:1];
    pos.y          = v_off[8:1];
    pos.char_col   = char_col;
    pos.char_pix   = char_pix;
    pos.half_pixel = hcount[0];
    pos.de         = hcount < H_ACTIVE && vcount < V_ACTIVE;
    pos.border     = h_border || v_border;
  end

  assign vga_hs = !(hcount >= H_ACTIVE + H_FRONT && hcount < H_ACTIVE + H_FRONT + H_SYNC);
  assign vga_vs = !(vcount >= V_ACTIVE + V_FRONT && vcount < V_ACTIVE + V_FRONT + V_SYNC);
  assign n_int  = !int_active;

endmodule

/* verilog/video_pkg.sv */
package video_pkg;

  // VGA 640x480 at 60 Hz, one clk per VGA pixel
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 11;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 31;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // Screen area placement, in VGA pixels and lines
  localparam int H_BORDER = 64;
  localparam int V_BORDER = 48;
  localparam int SCREEN_W = 256;
  localparam int SCREEN_H = 192;

  // Character layout of the two modes
  localparam int TEXT_LEFT   = 8;
  localparam int TEXT_COLS   = 40;
  localparam int GFX_COLS    = 32;
  localparam int CHAR_W_TEXT = 6;
  localparam int CHAR_W_GFX  = 8;

  localparam int INT_PULSE_LEN = 64;
  localparam int INT_CNT_W     = $clog2(INT_PULSE_LEN);

  localparam int VRAM_DEPTH = 16384;

  typedef logic [13:0] vram_addr_t;
  typedef logic [7:0]  vram_data_t;
  typedef logic [3:0]  color_index_t;
  typedef logic [23:0] rgb_t;
  typedef logic [7:0]  screen_coord_t;
  typedef logic [9:0]  hcount_t;
  typedef logic [9:0]  vcount_t;

  // Fixed TMS9918 colours, entry 0 is transparent
  localparam rgb_t PALETTE [16] = '{
    24'h000000, 24'h010101, 24'h3eb849, 24'h74d07d,
    24'h5955e0, 24'h8076f1, 24'h993e31, 24'h65dbef,
    24'hdb6559, 24'hff897d, 24'hccc35e, 24'hded087,
    24'h3aa241, 24'hb766b5, 24'h777777, 24'hffffff
  };

  typedef enum logic [0:0] {
    TEXT_MODE     = 1'b0,
    GRAPHICS_MODE = 1'b1
  } video_mode_t;

  typedef struct packed {
    video_mode_t  mode;
    logic         video_on;
    logic         vert_retrace_int;
    vram_addr_t   name_table_addr;
    vram_addr_t   pattern_table_addr;
    vram_addr_t   color_table_addr;
    color_index_t text_color;
    color_index_t back_color;
  } video_regs_t;

  typedef struct packed {
    hcount_t       hcount;
    vcount_t       vcount;
    screen_coord_t x;
    screen_coord_t y;
    logic [5:0]    char_col;
    logic [2:0]    char_pix;
    logic          half_pixel;
    logic          de;
    logic          border;
  } raster_pos_t;

  typedef enum logic [2:0] {
    IDLE,
    NAME_ADDR,
    PATTERN_ADDR,
    COLOR_ADDR,
    STORE
  } fetch_state_t;

endpackage

/* verilog/video_ram.sv */
module video_ram import video_pkg::*; (
  input  logic       clk,
  input  vram_addr_t cpu_addr,
  input  vram_data_t cpu_wdata,
  input  logic       cpu_we,
  input  logic       cpu_re,
  output vram_data_t cpu_rdata,
  input  vram_addr_t vid_addr,
  output vram_data_t vid_data
);

  vram_data_t mem [VRAM_DEPTH];

  // CPU port, write and read strobes with no handshake
  always_ff @(posedge clk) begin
    if (cpu_we) begin
      mem[cpu_addr] <= cpu_wdata;
    end
    if (cpu_re) begin
      cpu_rdata <= mem[cpu_addr];
    end
  end

  // Video port reads every cycle
  always_ff @(posedge clk) begin
    vid_data <= mem[vid_addr];
  end

endmodule

/* verilog/video_top.sv */
module video_top import video_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  video_regs_t regs,
  input  vram_addr_t  cpu_addr,
  input  vram_data_t  cpu_wdata,
  input  logic        cpu_we,
  input  logic        cpu_re,
  output logic [7:0]  vga_r,
  output logic [7:0]  vga_g,
  output logic [7:0]  vga_b,
  output logic        vga_hs,
  output logic        vga_vs,
  output logic        vga_de,
  output vram_data_t  cpu_rdata,
  output logic        n_int,
  output hcount_t     h_counter,
  output vcount_t     v_counter
);

  raster_pos_t pos;
  vram_addr_t  vid_addr;
  vram_data_t  vid_data;
  logic        load_pattern;
  logic        load_color;
  logic        pattern_bit;
  vram_data_t  cell_color;

  raster_timer raster_timer_i (
    .clk    (clk),
    .reset  (reset),
    .regs   (regs),
    .pos    (pos),
    .vga_hs (vga_hs),
    .vga_vs (vga_vs),
    .n_int  (n_int)
  );

  fetch_fsm fetch_fsm_i (
    .clk          (clk),
    .reset        (reset),
    .regs         (regs),
    .pos          (pos),
    .vid_data     (vid_data),
    .vid_addr     (vid_addr),
    .load_pattern (load_pattern),
    .load_color   (load_color)
  );

  video_ram video_ram_i (
    .clk       (clk),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_we    (cpu_we),
    .cpu_re    (cpu_re),
    .cpu_rdata (cpu_rdata),
    .vid_addr  (vid_addr),
    .vid_data  (vid_data)
  );

  pattern_latch pattern_latch_i (
    .clk          (clk),
    .reset        (reset),
    .pos          (pos),
    .vid_data     (vid_data),
    .load_pattern (load_pattern),
    .load_color   (load_color),
    .pattern_bit  (pattern_bit),
    .cell_color   (cell_color)
  );

  pixel_color pixel_color_i (
    .regs        (regs),
    .pos         (pos),
    .pattern_bit (pattern_bit),
    .cell_color  (cell_color),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_de      (vga_de)
  );

  assign h_counter = pos.hcount;
  assign v_counter = pos.vcount;

endmodule
